/* hdl/ov5640_reg_table.svh */
// OV5640 power-up register list for DVP output
// Each word is {16-bit address, 8-bit value}
// An index past the end reads zero

function automatic ov5640_cfg_pkg::cfg_word_t ov5640_reg_word(
    input ov5640_cfg_pkg::reg_index_t idx
);
    ov5640_cfg_pkg::cfg_word_t word;
    case (idx)
        7'd0:    word = 24'h310311;      // Clock source select
        7'd1:    word = 24'h300882;      // Software reset on
        7'd2:    word = 24'h300802;      // Software reset off
        7'd3:    word = 24'h310303;      // System clock from PLL
        7'd4:    word = 24'h3017ff;      // Pad output enable
        7'd5:    word = 24'h3018ff;      // Pad output enable
        7'd6:    word = 24'h30341a;      // PLL charge pump and bit divider
        7'd7:    word = 24'h303511;      // System and MIPI divider
        7'd8:    word = 24'h3036b8;      // PLL multiplier
        7'd9:    word = 24'h303712;      // PLL root divider and pre-divider
        7'd10:   word = 24'h310801;      // PCLK and SCLK divider
        7'd11:   word = 24'h363036;      // Analog setting
        7'd12:   word = 24'h36310e;
        7'd13:   word = 24'h3632e2;
        7'd14:   word = 24'h363312;
        7'd15:   word = 24'h3621e0;      // Analog setting
        7'd16:   word = 24'h3704a0;
        7'd17:   word = 24'h37035a;
        7'd18:   word = 24'h371578;
        7'd19:   word = 24'h371701;
        7'd20:   word = 24'h370b60;
        7'd21:   word = 24'h37051a;
        7'd22:   word = 24'h390502;      // Sensor core setting
        7'd23:   word = 24'h390610;
        7'd24:   word = 24'h39010a;
        7'd25:   word = 24'h373112;
        7'd26:   word = 24'h360008;      // VCM control
        7'd27:   word = 24'h360133;      // VCM control
        7'd28:   word = 24'h302d60;      // System control
        7'd29:   word = 24'h362052;
        7'd30:   word = 24'h371b20;
        7'd31:   word = 24'h471c50;
        7'd32:   word = 24'h3a1360;      // Gain pre-scale
        7'd33:   word = 24'h3a1800;      // Gain ceiling high bits
        7'd34:   word = 24'h3a19ff;      // Gain ceiling low bits
        7'd35:   word = 24'h363513;
        7'd36:   word = 24'h363603;
        7'd37:   word = 24'h363440;
        7'd38:   word = 24'h362201;
        7'd39:   word = 24'h382041;      // Vertical flip and binning
        7'd40:   word = 24'h382107;      // Horizontal mirror and binning
        7'd41:   word = 24'h381431;      // X odd and even increment
        7'd42:   word = 24'h381531;      // Y odd and even increment
        7'd43:   word = 24'h380000;      // Window X start high
        7'd44:   word = 24'h380100;      // Window X start low
        7'd45:   word = 24'h380200;      // Window Y start high
        7'd46:   word = 24'h380300;      // Window Y start low
        7'd47:   word = 24'h38040a;      // Window X end high
        7'd48:   word = 24'h38053f;      // Window X end low
        7'd49:   word = 24'h380607;      // Window Y end high
        7'd50:   word = 24'h38079b;      // Window Y end low
        7'd51:   word = 24'h380802;      // Output width 640 high
        7'd52:   word = 24'h380980;      // Output width 640 low
        7'd53:   word = 24'h380a01;      // Output height 480 high
        7'd54:   word = 24'h380be0;      // Output height 480 low
        7'd55:   word = 24'h380c07;      // Total line length HTS high
        7'd56:   word = 24'h380d68;      // HTS low
        7'd57:   word = 24'h380e03;      // Total frame length VTS high
        7'd58:   word = 24'h380fd8;      // VTS low
        7'd59:   word = 24'h381000;      // ISP X offset high
        7'd60:   word = 24'h381110;      // ISP X offset low
        7'd61:   word = 24'h381200;      // ISP Y offset high
        7'd62:   word = 24'h381306;      // ISP Y offset low
        7'd63:   word = 24'h361800;
        7'd64:   word = 24'h361229;
        7'd65:   word = 24'h370864;
        7'd66:   word = 24'h370952;
        7'd67:   word = 24'h370c03;
        7'd68:   word = 24'h400102;      // Black level start line
        7'd69:   word = 24'h400402;      // Black level line count
        7'd70:   word = 24'h300000;      // Enable all core blocks
        7'd71:   word = 24'h30021c;      // Enable FIFO and format blocks
        7'd72:   word = 24'h3004ff;      // Core clock enables
        7'd73:   word = 24'h3006c3;      // Format clock enables
        7'd74:   word = 24'h300e58;      // DVP on and MIPI powered down
        7'd75:   word = 24'h302e00;
        7'd76:   word = 24'h430060;      // Output format RGB565
        7'd77:   word = 24'h501f01;      // Format mux to ISP RGB
        7'd78:   word = 24'h471303;      // JPEG mode select
        7'd79:   word = 24'h440704;      // Quantization scale
        7'd80:   word = 24'h440e00;
        7'd81:   word = 24'h460b35;      // VFIFO control
        7'd82:   word = 24'h460c22;      // PCLK divider source
        7'd83:   word = 24'h382402;      // DVP PCLK divider
        7'd84:   word = 24'h5000a7;      // ISP block enables
        7'd85:   word = 24'h5001a3;      // ISP block enables
        7'd86:   word = 24'h502500;
        7'd87:   word = 24'h3a0f30;      // Exposure stable range enter high
        7'd88:   word = 24'h3a1028;      // Exposure stable range enter low
        7'd89:   word = 24'h3a1b30;      // Exposure stable range exit high
        7'd90:   word = 24'h3a1e26;      // Exposure stable range exit low
        7'd91:   word = 24'h3a1160;      // Fast zone high limit
        7'd92:   word = 24'h3a1f14;      // Fast zone low limit
        7'd93:   word = 24'h40051a;      // Black level always update
        7'd94:   word = 24'h300802;      // Wake from reset
        7'd95:   word = 24'h303521;      // Final system clock divider
        default: word = '0;              // Past the table
    endcase
    return word;
endfunction

/* hdl/ov5640_cfg_pkg.sv */
package ov5640_cfg_pkg;

    // One sensor write as seen by the I2C master
    typedef logic [23:0] cfg_word_t;     // {reg_addr, reg_val}
    typedef logic [15:0] reg_addr_t;     // OV5640 register address
    typedef logic [7:0]  reg_val_t;      // Value written to that register

    // Table position including the one-past-end value
    typedef logic [6:0]  reg_index_t;

    localparam int REG_COUNT = 96;       // Entries in the register table

    // Loader sequencing
    typedef enum logic [2:0] {
        WAIT_READY,                      // Sensor still settling
        FETCH,                           // ROM read in flight
        ISSUE,                           // cfg_start pulse cycle
        BUSY,                            // Master writing the word
        DONE                             // Whole table written
    } seq_state_t;

endpackage

/* hdl/ov5640_powerup_timer.sv */
`timescale 1ns/10ps

module ov5640_powerup_timer #(
    parameter int POWERUP_CYCLES = 30000             // Settling time in clocks (at least 1)
) (
    input  logic sys_clk,
    input  logic sys_rst_n,
    output logic powerup_ready                        // High once the sensor has settled
);

    localparam int CNT_W = $clog2(POWERUP_CYCLES + 1);            // Holds the full count
    localparam logic [CNT_W-1:0] CNT_MAX  = CNT_W'(POWERUP_CYCLES);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(POWERUP_CYCLES - 1);

    logic [CNT_W-1:0] wait_cnt;                       // Cycles since reset release

    // Saturating count that raises ready on the POWERUP_CYCLES-th edge
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wait_cnt      <= '0;
            powerup_ready <= 1'b0;
        end else begin
            if (wait_cnt < CNT_MAX) begin
                wait_cnt <= wait_cnt + 1'b1;          // Stops at CNT_MAX
            end
            if (wait_cnt == CNT_LAST) begin
                powerup_ready <= 1'b1;                // Sticky until next reset
            end
        end
    end

    // Once the sensor is up it stays up
    a_ready_sticky: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        !$fell(powerup_ready)
    ) else $error("powerup_ready dropped without reset");

endmodule

/* hdl/ov5640_reg_rom.sv */
`timescale 1ns/10ps

module ov5640_reg_rom (
    input  logic                       sys_clk,
    input  logic                       sys_rst_n,
    input  ov5640_cfg_pkg::reg_index_t rom_index,    // Table entry to read
    output ov5640_cfg_pkg::cfg_word_t  cfg_data      // Word one clock later
);

    `include "ov5640_reg_table.svh"

    ov5640_cfg_pkg::cfg_word_t rom_word;             // Combinational table lookup
    ov5640_cfg_pkg::reg_addr_t addr_q;               // Registered address field
    ov5640_cfg_pkg::reg_val_t  val_q;                // Registered value field

    assign rom_word = ov5640_reg_word(rom_index);   // Zero beyond the last entry

    // Synchronous read port of the table
    always_ff @(posedge sys_clk) begin
        addr_q <= rom_word[23:8];
        val_q  <= rom_word[7:0];
    end

    assign cfg_data = {addr_q, val_q};

endmodule

/* hdl/ov5640_cfg_sequencer.sv */
`timescale 1ns/10ps

module ov5640_cfg_sequencer (
    input  logic                       sys_clk,
    input  logic                       sys_rst_n,
    input  logic                       powerup_ready,  // Level from the settling timer
    input  logic                       cfg_end,        // Master finished the word
    output ov5640_cfg_pkg::reg_index_t rom_index,      // Current table entry
    output logic                       cfg_start,      // One-cycle word trigger
    output logic                       cfg_done        // Table fully written
);

    localparam ov5640_cfg_pkg::reg_index_t LAST_INDEX =
        ov5640_cfg_pkg::reg_index_t'(ov5640_cfg_pkg::REG_COUNT - 1);
    localparam ov5640_cfg_pkg::reg_index_t END_INDEX =
        ov5640_cfg_pkg::reg_index_t'(ov5640_cfg_pkg::REG_COUNT);

    ov5640_cfg_pkg::seq_state_t state;               // Current state
    ov5640_cfg_pkg::seq_state_t state_nxt;           // Next state

    logic word_ack;                                  // cfg_end accepted in BUSY
    logic last_word;                                 // Index sits on the final entry

    assign word_ack  = (state == ov5640_cfg_pkg::BUSY) && cfg_end;
    assign last_word = (rom_index == LAST_INDEX);

    // Next-state logic
    always_comb begin
        state_nxt = state;                           // Hold by default
        case (state)
            ov5640_cfg_pkg::WAIT_READY: begin
                if (powerup_ready) begin
                    state_nxt = ov5640_cfg_pkg::FETCH;
                end
            end
            ov5640_cfg_pkg::FETCH: begin
                state_nxt = ov5640_cfg_pkg::ISSUE;   // ROM word valid next cycle
            end
            ov5640_cfg_pkg::ISSUE: begin
                state_nxt = ov5640_cfg_pkg::BUSY;
            end
            ov5640_cfg_pkg::BUSY: begin
                if (cfg_end) begin                   // No timeout on the master
                    state_nxt = last_word ? ov5640_cfg_pkg::DONE
                                          : ov5640_cfg_pkg::FETCH;
                end
            end
            ov5640_cfg_pkg::DONE: begin
                state_nxt = ov5640_cfg_pkg::DONE;    // Only reset leaves
            end
            default: begin
                state_nxt = ov5640_cfg_pkg::WAIT_READY;
            end
        endcase
    end

    // State, index and registered outputs
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state     <= ov5640_cfg_pkg::WAIT_READY;
            rom_index <= '0;
            cfg_start <= 1'b0;
            cfg_done  <= 1'b0;
        end else begin
            state     <= state_nxt;
            cfg_start <= (state == ov5640_cfg_pkg::FETCH);  // Pulse lines up with ISSUE
            if (word_ack) begin
                rom_index <= rom_index + 7'd1;       // Ends at REG_COUNT after last word
            end
            if (word_ack && last_word) begin
                cfg_done <= 1'b1;                    // Sticky until reset
            end
        end
    end

    // Trigger is a single-cycle pulse
    a_start_pulse: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        cfg_start |=> !cfg_start
    ) else $error("cfg_start held for more than one cycle");

    // Index never runs past one beyond the table
    a_index_range: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        rom_index <= END_INDEX
    ) else $error("rom_index beyond table end");

    // Completion is permanent for this load
    a_done_sticky: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        !$fell(cfg_done)
    ) else $error("cfg_done dropped without reset");

endmodule

/* hdl/ov5640_cfg_ctrl.sv */
`timescale 1ns/10ps

module ov5640_cfg_ctrl #(
    parameter int POWERUP_CYCLES = 30000             // Sensor settling time in clocks
) (
    input  logic                      sys_clk,
    input  logic                      sys_rst_n,
    input  logic                      cfg_end,       // Word written by the I2C master
    output logic                      cfg_start,     // Start one register write
    output ov5640_cfg_pkg::cfg_word_t cfg_data,      // {reg_addr, reg_val}
    output logic                      cfg_done       // All registers written
);

    logic                       powerup_ready;       // Timer to sequencer
    ov5640_cfg_pkg::reg_index_t rom_index;           // Sequencer to ROM

    // Settling delay after reset
    ov5640_powerup_timer #(
        .POWERUP_CYCLES (POWERUP_CYCLES)
    ) i_ov5640_powerup_timer (
        .sys_clk       (sys_clk),
        .sys_rst_n     (sys_rst_n),
        .powerup_ready (powerup_ready)
    );

    // Word-by-word handshake with the master
    ov5640_cfg_sequencer i_ov5640_cfg_sequencer (
        .sys_clk       (sys_clk),
        .sys_rst_n     (sys_rst_n),
        .powerup_ready (powerup_ready),
        .cfg_end       (cfg_end),
        .rom_index     (rom_index),
        .cfg_start     (cfg_start),
        .cfg_done      (cfg_done)
    );

    // Register table feeding the data port directly
    ov5640_reg_rom i_ov5640_reg_rom (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .rom_index (rom_index),
        .cfg_data  (cfg_data)
    );

endmodule

/* bench/tb_cfg_model.svh */
logic [31:0] rng_state;                          // LCG state seeded by the testbench

int cyc;                                         // Cycles since reset release
int exp_k;                                       // Next table entry expected
int starts;                                      // cfg_start pulses in this load
bit in_word;                                     // Between a start and its cfg_end
bit start_latch;                                 // Start seen at the last falling edge
int last_end_cyc;                                // Cycle of the last accepted cfg_end
int final_end_cyc;                               // Cycle of the final cfg_end or -1
ov5640_cfg_pkg::cfg_word_t exp_word;             // Word that must sit on cfg_data

// 32-bit LCG step
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// Integer in [lo, hi] from the upper state bits
function automatic int rand_range(input int lo, input int hi);
    rng_state = lcg_next(rng_state);
    return lo + int'({16'h0000, rng_state[31:16]} % (hi - lo + 1));
endfunction

// Timer fires on edge P, FETCH on P+1, ISSUE pulse on P+2
function automatic int first_start_cycle();
    return POWERUP_CYCLES + 2;
endfunction

// One cycle to accept cfg_end and one for the ROM read
function automatic int next_start_cycle(input int end_cyc);
    return end_cyc + 2;
endfunction

// Index reaches REG_COUNT one cycle after the last cfg_end and the ROM adds one more
function automatic int zero_data_cycle();
    return final_end_cyc + 2;
endfunction

task automatic model_reset();
    cyc           = -1;                          // First cycle after release is 0
    exp_k         = 0;
    starts        = 0;
    in_word       = 1'b0;
    start_latch   = 1'b0;
    last_end_cyc  = -1;
    final_end_cyc = -1;
    exp_word      = '0;
endtask

// Master finished the current word
task automatic model_accept_end();
    last_end_cyc = cyc;
    in_word      = 1'b0;
    exp_k        = exp_k + 1;
    if (exp_k == REG_COUNT) begin
        final_end_cyc = cyc;                     // Done due on the next cycle
    end
endtask

/* bench/tb_ov5640_cfg_ctrl.sv */
`timescale 1ns/10ps

module tb_ov5640_cfg_ctrl;

    localparam int POWERUP_CYCLES = 200;         // Short settling time for simulation
    localparam int REG_COUNT      = ov5640_cfg_pkg::REG_COUNT;
    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 16;
    localparam int MAX_LATENCY    = 20;          // Slowest master response
    localparam int TAIL_CYCLES    = 50;          // Quiet window after completion
    localparam int LOAD_CYCLES    =
        RESET_CYCLES + POWERUP_CYCLES + 2 + REG_COUNT * (MAX_LATENCY + 2);
    localparam int WATCHDOG_CYCLES = 2 * LOAD_CYCLES * 12 / 10;   // Two loads plus 20%

    localparam int T_POWER   = 0;
    localparam int T_WORD    = 1;
    localparam int T_SPACING = 2;
    localparam int T_DONE    = 3;
    localparam int T_RESTART = 4;
    localparam int NUM_TESTS = 5;

    logic                      sys_clk = 1'b0;
    logic                      sys_rst_n;
    logic                      cfg_end;
    logic                      cfg_start;
    ov5640_cfg_pkg::cfg_word_t cfg_data;
    logic                      cfg_done;

    bit    inject_en;                            // Stray cfg_end pulses allowed
    bit    restart_phase;                        // Failures count against the restart test
    int    wait_left;                            // Responder countdown to cfg_end
    int    rst_cyc;                              // Falling edges seen inside reset
    int    checks;                               // Checks made
    int    test_errs [NUM_TESTS];
    string test_name [NUM_TESTS];

    `include "ov5640_reg_table.svh"
    `include "tb_cfg_model.svh"

    ov5640_cfg_ctrl #(
        .POWERUP_CYCLES (POWERUP_CYCLES)
    ) i_ov5640_cfg_ctrl (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .cfg_end   (cfg_end),
        .cfg_start (cfg_start),
        .cfg_data  (cfg_data),
        .cfg_done  (cfg_done)
    );

    always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

    function automatic int error_total();
        int sum;
        sum = 0;
        foreach (test_errs[i]) begin
            sum += test_errs[i];
        end
        return sum;
    endfunction

    task automatic report_mismatch(input int t, input string what,
                                   input logic [31:0] exp_v, input logic [31:0] act_v);
        int id;
        id = restart_phase ? T_RESTART : t;      // Second load reports under restart
        test_errs[id]++;
        $display("[ERROR] %s: %s expected %h actual %h (cycle %0d)",
                 test_name[id], what, exp_v, act_v, cyc);
    endtask

    task automatic report_fault(input int t, input string msg);
        int id;
        id = restart_phase ? T_RESTART : t;
        test_errs[id]++;
        $display("Failure in %s at cycle %0d: %s", test_name[id], cyc, msg);
    endtask

    task automatic finish_test(input int t);
        if (test_errs[t] == 0) begin
            $display("test %s: passed", test_name[t]);
        end else begin
            $display("test %s: failed with %0d mismatches", test_name[t], test_errs[t]);
        end
    endtask

    // Model update and checks for one cycle out of reset
    task automatic check_cycle();
        if (cfg_start) begin
            starts++;
            checks++;
            if (in_word) begin
                report_fault(T_SPACING, "cfg_start repeated before cfg_end");
            end
            if (exp_k >= REG_COUNT) begin
                report_fault(T_DONE, "cfg_start after the last word");
            end else begin
                if (exp_k == 0 && cyc != first_start_cycle()) begin
                    report_mismatch(T_POWER, "first start cycle", first_start_cycle(), cyc);
                end
                if (exp_k > 0 && cyc != next_start_cycle(last_end_cyc)) begin
                    report_mismatch(T_SPACING, "start cycle",
                                    next_start_cycle(last_end_cyc), cyc);
                end
                exp_word = ov5640_reg_word(ov5640_cfg_pkg::reg_index_t'(exp_k));
                if (cfg_data !== exp_word) begin
                    report_mismatch(T_WORD, "word at start", {8'h00, exp_word},
                                    {8'h00, cfg_data});
                end
                in_word = 1'b1;
            end
        end else if (in_word) begin
            checks++;
            if (cfg_data !== exp_word) begin    // Must hold through back-pressure
                report_mismatch(T_WORD, "word held", {8'h00, exp_word}, {8'h00, cfg_data});
            end
        end
        if (cfg_end && in_word) begin
            model_accept_end();                  // Stray pulses outside a word are ignored
        end
        checks++;
        if (final_end_cyc < 0 || cyc == final_end_cyc) begin
            if (cfg_done !== 1'b0) begin
                report_mismatch(starts == 0 ? T_POWER : T_DONE, "cfg_done", 0, 32'(cfg_done));
            end
        end else if (cfg_done !== 1'b1) begin
            report_mismatch(T_DONE, "cfg_done", 1, 32'(cfg_done));
        end
        if (final_end_cyc >= 0 && cyc >= zero_data_cycle() && cfg_data !== '0) begin
            report_mismatch(T_DONE, "data after completion", 0, {8'h00, cfg_data});
        end
    endtask

    // Monitor on the falling edge where outputs are settled
    always @(negedge sys_clk) begin
        start_latch = sys_rst_n && cfg_start;
        if (!sys_rst_n) begin
            rst_cyc++;
            model_reset();
            if (rst_cyc > 1) begin               // ROM output needs one edge to load entry 0
                checks++;
                if (cfg_start !== 1'b0 || cfg_done !== 1'b0) begin
                    report_fault(T_POWER, "cfg_start or cfg_done high during reset");
                end
                if (cfg_data !== ov5640_reg_word(ov5640_cfg_pkg::reg_index_t'(0))) begin
                    report_mismatch(T_POWER, "data in reset",
                                    {8'h00, ov5640_reg_word(ov5640_cfg_pkg::reg_index_t'(0))},
                                    {8'h00, cfg_data});
                end
            end
        end else begin
            rst_cyc = 0;
            cyc++;
            check_cycle();
        end
    end

    // I2C master model answering each start after a random delay
    always @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            wait_left = 0;
            cfg_end   <= 1'b0;
        end else begin
            if (start_latch) begin
                wait_left = rand_range(1, MAX_LATENCY);
            end
            if (wait_left > 0) begin
                wait_left = wait_left - 1;
                cfg_end   <= (wait_left == 0);   // One-cycle pulse
            end else if (inject_en) begin
                cfg_end   <= (rand_range(0, 5) == 0);
            end else begin
                cfg_end   <= 1'b0;
            end
        end
    end

    task automatic apply_reset();
        @(posedge sys_clk);
        sys_rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge sys_clk);
        sys_rst_n <= 1'b1;
    endtask

    // Stray cfg_end pulses while the sensor settles
    task automatic settle_with_noise();
        @(negedge sys_clk);
        inject_en = 1'b1;
        repeat (POWERUP_CYCLES - 20) @(posedge sys_clk);
        @(negedge sys_clk);
        inject_en = 1'b0;
    endtask

    initial begin
        int restart_at;
        sys_rst_n     = 1'b0;
        cfg_end       = 1'b0;
        inject_en     = 1'b0;
        restart_phase = 1'b0;
        rng_state     = 32'hf656;
        checks        = 0;
        rst_cyc       = 0;
        test_name     = '{"power_up_delay", "word_order", "inter_word_spacing",
                          "completion", "restart_on_reset"};
        foreach (test_errs[i]) begin
            test_errs[i] = 0;
        end
        model_reset();
        restart_at = rand_range(1, REG_COUNT - 2);   // Entry at which the second load is cut

        repeat (RESET_CYCLES) @(posedge sys_clk);
        sys_rst_n <= 1'b1;
        settle_with_noise();
        wait (starts > 0);
        @(posedge sys_clk);
        finish_test(T_POWER);
        wait (exp_k == REG_COUNT);
        @(posedge sys_clk);
        finish_test(T_WORD);

        @(negedge sys_clk);
        inject_en = 1'b1;                        // Stray ends must not restart the load
        repeat (TAIL_CYCLES) @(posedge sys_clk);
        @(negedge sys_clk);
        inject_en = 1'b0;
        @(posedge sys_clk);
        checks++;
        if (starts != REG_COUNT) begin
            report_mismatch(T_SPACING, "start pulse count", REG_COUNT, starts);
        end
        finish_test(T_SPACING);
        finish_test(T_DONE);

        restart_phase = 1'b1;
        apply_reset();
        settle_with_noise();
        wait (exp_k == restart_at);
        apply_reset();                           // Cut the load mid-table
        @(posedge sys_clk);
        checks++;
        if (cfg_done !== 1'b0) begin
            report_mismatch(T_RESTART, "cfg_done after reset", 0, 32'(cfg_done));
        end
        settle_with_noise();
        wait (exp_k == REG_COUNT);
        repeat (5) @(posedge sys_clk);
        checks++;
        if (cfg_done !== 1'b1) begin
            report_mismatch(T_RESTART, "cfg_done after reload", 1, 32'(cfg_done));
        end
        if (starts != REG_COUNT) begin
            report_mismatch(T_RESTART, "start pulse count", REG_COUNT, starts);
        end
        finish_test(T_RESTART);

        $display("summary: %0d tests, %0d checks, %0d failed", NUM_TESTS, checks,
                 error_total());
        if (error_total() == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog sized from two worst-case loads
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the load did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("summary: %0d tests, %0d checks, %0d failed", NUM_TESTS, checks,
                 error_total() + 1);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* compile.f */
+incdir+hdl
+incdir+bench
hdl/ov5640_cfg_pkg.sv
hdl/ov5640_powerup_timer.sv
hdl/ov5640_reg_rom.sv
hdl/ov5640_cfg_sequencer.sv
hdl/ov5640_cfg_ctrl.sv
bench/tb_ov5640_cfg_ctrl.sv

/* Makefile */
# Verilator build and run for the OV5640 register loader testbench

VERILATOR ?= verilator
TOP       ?= tb_ov5640_cfg_ctrl
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard hdl/*.svh bench/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
